// ==== src/fetch_types_pkg.sv ====
package fetch_types_pkg;

    // datapath widths
    localparam int ADDR_W = 64;
    localparam int INST_W = 32;
    localparam int DATA_W = 64;

    // byte address into the fetch space
    typedef logic [ADDR_W-1:0] addr_t;

    // one uncompressed instruction word
    typedef logic [INST_W-1:0] inst_t;

    // one read data beat, two instructions wide
    typedef logic [DATA_W-1:0] bus_data_t;

    // pc step and fixed fetch size in bytes
    localparam addr_t INST_BYTES = 64'd4;

endpackage

// ==== src/fetch_ctrl_pkg.sv ====
package fetch_ctrl_pkg;

    // read bus request FSM
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_e;

    // cause that moves the pc off its sequential path
    typedef enum logic [1:0] {
        NONE,
        JUMP,
        JALR,
        TRAP
    } redirect_e;

endpackage

// ==== src/trap_vec_regs.sv ====
`timescale 1ns/1ps

module trap_vec_regs
    import fetch_types_pkg::*;
#(
    parameter addr_t RESET_TVEC = 64'h8000_0100
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  tvec_we_i,
    input  addr_t tvec_wdata_i,
    output addr_t tvec_o
);

    addr_t tvec_q;

    // direct mode only, low two bits forced to zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            tvec_q <= RESET_TVEC;
        end else if (tvec_we_i) begin
            tvec_q <= {tvec_wdata_i[63:2], 2'b00};
        end
    end

    // a write shows up one cycle later, so a same-cycle trap sees the old base
    assign tvec_o = tvec_q;

    // also catches a misaligned reset value
    a_tvec_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        tvec_o[1:0] == 2'b00
    ) else $error("trap vector not aligned: %h", tvec_o);

endmodule

// ==== src/next_pc.sv ====
`timescale 1ns/1ps

module next_pc
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
#(
    parameter addr_t RESET_PC = 64'h8000_0000
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  jump_i,
    input  logic  branch_i,
    input  logic  cmp_zero_i,
    input  logic  jalr_i,
    input  logic  trap_i,
    input  logic  pc_hold_i,
    input  addr_t ex_pc_i,
    input  addr_t ex_imm_i,
    input  addr_t ex_rs1_i,
    input  addr_t tvec_i,
    input  logic  beat_done_i,
    input  addr_t beat_addr_i,
    output addr_t pc_o,
    output logic  redirect_o
);

    addr_t     pc_q;
    addr_t     jalr_sum;
    addr_t     target;
    redirect_e cause;
    logic      step;

    assign jalr_sum = ex_rs1_i + ex_imm_i;

    // jal and taken branch first, then jalr, trap last
    always_comb begin
        cause  = NONE;
        target = pc_q;
        if (jump_i || (branch_i && cmp_zero_i)) begin
            cause  = JUMP;
            target = ex_pc_i + ex_imm_i;
        end else if (jalr_i) begin
            cause  = JALR;
            target = {jalr_sum[63:1], 1'b0};
        end else if (trap_i) begin
            cause  = TRAP;
            target = tvec_i;
        end
    end

    assign redirect_o = (cause != NONE);

    // sequential advance only once the current pc has been delivered
    assign step = beat_done_i && (beat_addr_i == pc_q) && !pc_hold_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_o) begin
            pc_q <= target;
        end else if (step) begin
            pc_q <= pc_q + INST_BYTES;
        end
    end

    assign pc_o = pc_q;

    // jalr may leave bit 1 set, everything else keeps word alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        (cause != JALR) |=> (pc_o[1:0] == 2'b00)
    ) else $warning("pc not word aligned: %h", pc_o);

endmodule

// ==== src/fetch_req.sv ====
`timescale 1ns/1ps

module fetch_req
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  addr_t     pc_i,
    input  logic      redirect_i,
    input  logic      ar_ready_i,
    input  logic      r_valid_i,
    input  bus_data_t r_data_i,
    output logic      ar_valid_o,
    output addr_t     ar_addr_o,
    output logic      r_ready_o,
    output logic      beat_done_o,
    output addr_t     beat_addr_o,
    output logic      inst_valid_o,
    output inst_t     inst_o,
    output addr_t     inst_pc_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        addr_q;
    logic         first_q;
    logic         stale_q;
    logic         new_req;
    logic         beat_xfer;
    logic         fresh;
    logic         inst_valid_q;
    inst_t        inst_q;
    addr_t        inst_pc_q;

    assign ar_valid_o = (state_q == ADDR);
    assign r_ready_o  = (state_q == DATA);

    // first request cycle takes pc directly, so a pc bumped by the last beat goes out at once
    assign ar_addr_o = first_q ? pc_i : addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                state_d = ADDR;
            end
            ADDR: begin
                if (ar_ready_i) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                if (r_valid_i) begin
                    state_d = ADDR;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign new_req = (state_q != ADDR) && (state_d == ADDR);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            first_q <= 1'b0;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= new_req;
            // sticky until the next request starts
            if (new_req) begin
                stale_q <= 1'b0;
            end else if (state_q != IDLE && (redirect_i || pc_i != ar_addr_o)) begin
                stale_q <= 1'b1;
            end
        end
    end

    // in-flight address
    always_ff @(posedge clk) begin
        if (state_q == ADDR) begin
            addr_q <= ar_addr_o;
        end
    end

    assign beat_xfer = r_valid_i && r_ready_o;

    // drop beats for an old pc, including one that lands with a redirect
    assign fresh = beat_xfer && !stale_q && !redirect_i && (pc_i == addr_q);

    assign beat_done_o = fresh;
    assign beat_addr_o = addr_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= fresh;
        end
    end

    // addr bit 2 picks the upper half of the beat
    always_ff @(posedge clk) begin
        if (fresh) begin
            inst_q    <= addr_q[2] ? r_data_i[63:32] : r_data_i[31:0];
            inst_pc_q <= addr_q;
        end
    end

    assign inst_valid_o = inst_valid_q;
    assign inst_o       = inst_q;
    assign inst_pc_o    = inst_pc_q;

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
    ) else $error("ar request changed before handshake");

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_types_pkg::*;
#(
    parameter addr_t RESET_PC   = 64'h8000_0000,
    parameter addr_t RESET_TVEC = 64'h8000_0100
) (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      jump_i,
    input  logic      branch_i,
    input  logic      cmp_zero_i,
    input  logic      jalr_i,
    input  logic      trap_i,
    input  logic      pc_hold_i,
    input  addr_t     ex_pc_i,
    input  addr_t     ex_imm_i,
    input  addr_t     ex_rs1_i,
    input  logic      tvec_we_i,
    input  addr_t     tvec_wdata_i,
    input  logic      ar_ready_i,
    input  logic      r_valid_i,
    input  bus_data_t r_data_i,
    output logic      ar_valid_o,
    output addr_t     ar_addr_o,
    output logic      r_ready_o,
    output logic      inst_valid_o,
    output inst_t     inst_o,
    output addr_t     inst_pc_o
);

    addr_t tvec;
    addr_t pc;
    logic  redirect;
    logic  beat_done;
    addr_t beat_addr;

    trap_vec_regs #(
        .RESET_TVEC (RESET_TVEC)
    ) tvec_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .tvec_we_i    (tvec_we_i),
        .tvec_wdata_i (tvec_wdata_i),
        .tvec_o       (tvec)
    );

    next_pc #(
        .RESET_PC (RESET_PC)
    ) pc_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .jump_i      (jump_i),
        .branch_i    (branch_i),
        .cmp_zero_i  (cmp_zero_i),
        .jalr_i      (jalr_i),
        .trap_i      (trap_i),
        .pc_hold_i   (pc_hold_i),
        .ex_pc_i     (ex_pc_i),
        .ex_imm_i    (ex_imm_i),
        .ex_rs1_i    (ex_rs1_i),
        .tvec_i      (tvec),
        .beat_done_i (beat_done),
        .beat_addr_i (beat_addr),
        .pc_o        (pc),
        .redirect_o  (redirect)
    );

    // bus side, one read at a time
    fetch_req req_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .pc_i         (pc),
        .redirect_i   (redirect),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_data_i     (r_data_i),
        .ar_valid_o   (ar_valid_o),
        .ar_addr_o    (ar_addr_o),
        .r_ready_o    (r_ready_o),
        .beat_done_o  (beat_done),
        .beat_addr_o  (beat_addr),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o)
    );

endmodule

// ==== tests/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import fetch_types_pkg::*;
#(
    parameter addr_t RESET_PC   = 64'h8000_0000,
    parameter addr_t RESET_TVEC = 64'h8000_0100
) ();

    logic      clk = 1'b0;
    logic      rst_i;
    logic      jump_i;
    logic      branch_i;
    logic      cmp_zero_i;
    logic      jalr_i;
    logic      trap_i;
    logic      pc_hold_i;
    addr_t     ex_pc_i;
    addr_t     ex_imm_i;
    addr_t     ex_rs1_i;
    logic      tvec_we_i;
    addr_t     tvec_wdata_i;
    logic      ar_ready_i;
    logic      r_valid_i;
    bus_data_t r_data_i;
    logic      ar_valid_o;
    addr_t     ar_addr_o;
    logic      r_ready_o;
    logic      inst_valid_o;
    inst_t     inst_o;
    addr_t     inst_pc_o;

    // reference model state
    logic [31:0] lcg_state = 32'hfc4b;
    addr_t       m_pc;
    addr_t       m_tvec;
    addr_t       req_addr;
    logic        in_data;
    logic        req_new;
    logic        req_stale;
    logic        exp_valid;
    addr_t       exp_pc;
    int          idle_cycles;

    // memory responder state
    addr_t       resp_addr;
    logic        resp_busy;
    int          resp_delay;
    logic        nxt_r_valid;
    bus_data_t   nxt_r_data;

    fetch_top #(
        .RESET_PC   (RESET_PC),
        .RESET_TVEC (RESET_TVEC)
    ) dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ {16'b0, lcg_state[31:16]};
    endfunction

    // memory contents, a hash of the word address
    function automatic inst_t word_at(addr_t a);
        logic [31:0] h;
        h = a[31:0] ^ a[63:32];
        h = h * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    function automatic bus_data_t beat_at(addr_t a);
        addr_t base;
        base = {a[63:3], 3'b000};
        return {word_at(base | 64'd4), word_at(base)};
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one cycle of the model, sampled mid cycle
    task automatic model_cycle();
        logic  redir;
        logic  fresh;
        addr_t target;
        check_val("inst_valid_o", {63'b0, exp_valid}, {63'b0, inst_valid_o});
        if (exp_valid) begin
            check_val("inst_o", {32'b0, word_at(exp_pc)}, {32'b0, inst_o});
            check_val("inst_pc_o", exp_pc, inst_pc_o);
            idle_cycles = 0;
        end else begin
            idle_cycles++;
        end
        if (idle_cycles > 200) begin
            $display("no instruction delivered for 200 cycles at %0t ns", $time);
            $display("sim failed");
            $fatal(1, "fetch stopped making progress");
        end
        check_val("ar_valid_o", {63'b0, !in_data}, {63'b0, ar_valid_o});
        check_val("r_ready_o", {63'b0, in_data}, {63'b0, r_ready_o});
        // address comes from pc in the first request cycle, then must hold
        if (!in_data) begin
            if (req_new) begin
                req_addr = m_pc;
            end
            check_val("ar_addr_o", req_addr, ar_addr_o);
        end
        req_new = 1'b0;
        redir = 1'b1;
        if (jump_i || (branch_i && cmp_zero_i)) begin
            target = ex_pc_i + ex_imm_i;
        end else if (jalr_i) begin
            target = (ex_rs1_i + ex_imm_i) & ~64'd1;
        end else if (trap_i) begin
            target = m_tvec;
        end else begin
            redir = 1'b0;
            target = m_pc;
        end
        // a redirect in the beat cycle also marks the beat stale
        if (redir) begin
            req_stale = 1'b1;
        end
        fresh = 1'b0;
        exp_valid = 1'b0;
        if (in_data && r_valid_i) begin
            fresh = !req_stale && (req_addr == m_pc);
            exp_valid = fresh;
            exp_pc = req_addr;
            in_data = 1'b0;
            req_new = 1'b1;
            req_stale = 1'b0;
        end else if (!in_data && ar_ready_i) begin
            in_data = 1'b1;
        end
        if (redir) begin
            m_pc = target;
        end else if (fresh && !pc_hold_i) begin
            m_pc = m_pc + 64'd4;
        end
        if (tvec_we_i) begin
            m_tvec = {tvec_wdata_i[63:2], 2'b00};
        end
    endtask

    task automatic respond();
        nxt_r_valid = r_valid_i;
        nxt_r_data = r_data_i;
        if (ar_valid_o && ar_ready_i) begin
            resp_busy = 1'b1;
            resp_addr = ar_addr_o;
            resp_delay = int'(next_rand() % 6);
        end
        if (r_valid_i && r_ready_o) begin
            nxt_r_valid = 1'b0;
            resp_busy = 1'b0;
        end else if (resp_busy && !r_valid_i) begin
            if (resp_delay == 0) begin
                nxt_r_valid = 1'b1;
                nxt_r_data = beat_at(resp_addr);
            end else begin
                resp_delay--;
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic        redir_draw;
        logic        tvec_draw;
        ar_ready_i <= (next_rand() % 3) != 0;
        pc_hold_i <= (next_rand() % 8) == 0;
        r_valid_i <= nxt_r_valid;
        r_data_i <= nxt_r_data;
        redir_draw = (next_rand() % 16) == 0;
        tvec_draw = (next_rand() % 32) == 0;
        r = next_rand();
        // flags drawn together so that priority gets exercised
        jump_i <= redir_draw && r[0];
        branch_i <= redir_draw && r[1];
        cmp_zero_i <= r[2];
        jalr_i <= redir_draw && r[3];
        trap_i <= (redir_draw && r[4]) || (tvec_draw && r[5]);
        tvec_we_i <= tvec_draw;
        tvec_wdata_i <= {32'b0, 32'h8000_0000 | (next_rand() & 32'h3fff)};
        ex_pc_i <= RESET_PC + {52'b0, r[27:18], 2'b00};
        r = next_rand();
        ex_imm_i <= {{52{r[11]}}, r[11:2], 2'b00};
        // bit 0 of rs1 is random, the jalr target must clear it
        ex_rs1_i <= RESET_PC + {51'b0, r[24:14], 1'b0, r[0]};
    endtask

    initial begin
        int waited;
        rst_i <= 1'b1;
        jump_i <= 1'b0;
        branch_i <= 1'b0;
        cmp_zero_i <= 1'b0;
        jalr_i <= 1'b0;
        trap_i <= 1'b0;
        pc_hold_i <= 1'b0;
        ex_pc_i <= '0;
        ex_imm_i <= '0;
        ex_rs1_i <= '0;
        tvec_we_i <= 1'b0;
        tvec_wdata_i <= '0;
        ar_ready_i <= 1'b0;
        r_valid_i <= 1'b0;
        r_data_i <= '0;
        m_pc = RESET_PC;
        m_tvec = RESET_TVEC;
        req_addr = RESET_PC;
        in_data = 1'b0;
        req_new = 1'b1;
        req_stale = 1'b0;
        exp_valid = 1'b0;
        exp_pc = '0;
        idle_cycles = 0;
        resp_addr = '0;
        resp_busy = 1'b0;
        resp_delay = 0;
        nxt_r_valid = 1'b0;
        nxt_r_data = '0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_val("ar_valid_o", 64'd0, {63'b0, ar_valid_o});
        check_val("r_ready_o", 64'd0, {63'b0, r_ready_o});
        check_val("inst_valid_o", 64'd0, {63'b0, inst_valid_o});
        waited = 0;
        while (!ar_valid_o) begin
            if (waited == 10) begin
                $display("no read request within 10 cycles after reset");
                $display("sim failed");
                $fatal(1, "first request timed out");
            end
            waited++;
            @(negedge clk);
        end
        check_val("ar_addr_o", RESET_PC, ar_addr_o);
        for (int cyc = 0; cyc < 2000; cyc++) begin
            model_cycle();
            respond();
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
src/fetch_types_pkg.sv
src/fetch_ctrl_pkg.sv
src/trap_vec_regs.sv
src/next_pc.sv
src/fetch_req.sv
src/fetch_top.sv
tests/tb_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# verilator build and run of the fetch stage testbench

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module tb_fetch -f files.f -o tb_fetch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_fetch 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
